// ==== rtl/mem_config.svh ====
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// ----------------------------------------------------------------------
// memory map of the subsystem
// ----------------------------------------------------------------------

`define RAM_WORDS       1024            // ram depth in 32-bit words
`define RAM_BASE        32'h0000_0000
`define TIMER_BASE      32'h0200_0000
`define TIMER_SPAN      32'd16          // four 32-bit timer registers

// ----------------------------------------------------------------------
// timer register byte offsets from TIMER_BASE
// ----------------------------------------------------------------------

`define TMR_MTIME_LO    4'h0
`define TMR_MTIME_HI    4'h4
`define TMR_CMP_LO      4'h8
`define TMR_CMP_HI      4'hC

`endif

// ==== rtl/bus_pkg.sv ====
`default_nettype none

package bus_pkg;

    // ------------------------------------------------------------------
    // processor side sequencing
    // ------------------------------------------------------------------

    // arbiter FSM, a saved request waits in issue until the bus takes it
    typedef enum logic [1:0] {
        idle      = 2'd0,
        issue     = 2'd1,
        wait_read = 2'd2
    } arb_state_t;

    // which processor port owns the command on the bus
    typedef enum logic {
        src_inst = 1'b0,
        src_data = 1'b1
    } req_src_t;

endpackage

`default_nettype wire

// ==== rtl/map_pkg.sv ====
`default_nettype none

package map_pkg;

    // ------------------------------------------------------------------
    // address map decode results
    // ------------------------------------------------------------------

    typedef enum logic [1:0] {
        reg_ram   = 2'd0,
        reg_timer = 2'd1,
        reg_none  = 2'd2    // unmapped, reads give zero
    } region_t;

    // follows address bits 3:2 inside the timer window
    typedef enum logic [1:0] {
        mtime_lo = 2'd0,
        mtime_hi = 2'd1,
        cmp_lo   = 2'd2,
        cmp_hi   = 2'd3
    } timer_sel_t;

endpackage

`default_nettype wire

// ==== rtl/mem_cmd_if.sv ====
`default_nettype none

interface mem_cmd_if;

    logic                start;       // command offered by the arbiter
    logic                write;
    logic [31:0]         addr;
    logic [31:0]         wdata;
    logic [3:0]          wmask;
    bus_pkg::req_src_t   src;         // owner of the command in flight

    logic                ready;       // low while the controller is busy
    logic [31:0]         rdata;
    logic                rdata_valid; // one cycle pulse per read

    modport arbiter (
        output start, write, addr, wdata, wmask, src,
        input  ready, rdata, rdata_valid
    );

    modport controller (
        input  start, write, addr, wdata, wmask, src,
        output ready, rdata, rdata_valid
    );

endinterface

`default_nettype wire

// ==== rtl/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter (
    input  logic        clk,
    input  logic        arst_n,

    input  logic        ireq_valid,
    input  logic [31:0] ireq_addr,
    output logic        ireq_ready,
    output logic        iresp_valid,
    output logic [31:0] iresp_addr,
    output logic [31:0] iresp_inst,

    input  logic        dreq_valid,
    input  logic        dreq_wen,
    input  logic [31:0] dreq_addr,
    input  logic [31:0] dreq_wdata,
    input  logic [3:0]  dreq_wmask,
    output logic        dreq_ready,
    output logic        dresp_valid,
    output logic [31:0] dresp_addr,
    output logic [31:0] dresp_data,

    mem_cmd_if.arbiter  cmd
);

    bus_pkg::arb_state_t state;
    bus_pkg::req_src_t   owner;

    logic        ipend;
    logic        dpend;
    logic [31:0] iaddr_q;
    logic        dwen_q;
    logic [31:0] daddr_q;
    logic [31:0] dwdata_q;
    logic [3:0]  dwmask_q;
    logic        cmd_fire;

    // ------------------------------------------------------------------
    // command bus, fetch always goes first
    // ------------------------------------------------------------------

    assign owner    = ipend ? bus_pkg::src_inst : bus_pkg::src_data;
    assign cmd_fire = cmd.start && cmd.ready;

    assign cmd.start = state == bus_pkg::issue;
    assign cmd.src   = owner;
    assign cmd.write = (owner == bus_pkg::src_data) && dwen_q;
    assign cmd.addr  = (owner == bus_pkg::src_inst) ? iaddr_q : daddr_q;
    assign cmd.wdata = dwdata_q;
    assign cmd.wmask = dwmask_q;

    assign ireq_ready = state == bus_pkg::idle; // both ports share one ready
    assign dreq_ready = state == bus_pkg::idle;

    // ------------------------------------------------------------------
    // responses follow the owner of the read in flight
    // ------------------------------------------------------------------

    assign iresp_valid = (state == bus_pkg::wait_read) && cmd.rdata_valid
                         && (cmd.src == bus_pkg::src_inst);
    assign iresp_addr  = iaddr_q;
    assign iresp_inst  = cmd.rdata;

    assign dresp_valid = (state == bus_pkg::wait_read) && cmd.rdata_valid
                         && (cmd.src == bus_pkg::src_data);
    assign dresp_addr  = daddr_q;
    assign dresp_data  = cmd.rdata;

    // request payload is captured at acceptance
    always_ff @(posedge clk) begin
        if (ireq_ready && ireq_valid) begin
            iaddr_q <= ireq_addr;
        end
        if (dreq_ready && dreq_valid) begin
            dwen_q   <= dreq_wen;
            daddr_q  <= dreq_addr;
            dwdata_q <= dreq_wdata;
            dwmask_q <= dreq_wmask;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= bus_pkg::idle;
            ipend <= 1'b0;
            dpend <= 1'b0;
        end else begin
            case (state)
                bus_pkg::idle: begin
                    if (ireq_valid) begin
                        ipend <= 1'b1;
                    end
                    if (dreq_valid) begin
                        dpend <= 1'b1;
                    end
                    if (ireq_valid || dreq_valid) begin
                        state <= bus_pkg::issue;
                    end
                end
                bus_pkg::issue: begin
                    if (cmd_fire) begin
                        if (cmd.write) begin
                            dpend <= 1'b0;          // stores get no response
                            state <= bus_pkg::idle;
                        end else begin
                            state <= bus_pkg::wait_read;
                        end
                    end
                end
                bus_pkg::wait_read: begin
                    if (cmd.rdata_valid) begin
                        if (owner == bus_pkg::src_inst) begin
                            ipend <= 1'b0;
                            state <= dpend ? bus_pkg::issue : bus_pkg::idle;
                        end else begin
                            dpend <= 1'b0;
                            state <= bus_pkg::idle;
                        end
                    end
                end
                default: begin
                    state <= bus_pkg::idle;
                end
            endcase
        end
    end

    a_one_response: assert property (@(posedge clk) disable iff (!arst_n)
        !(iresp_valid && dresp_valid));

endmodule

`default_nettype wire

// ==== rtl/mem_map_ctrl.sv ====
`default_nettype none

`include "mem_config.svh"

module mem_map_ctrl (
    input  logic                clk,
    input  logic                arst_n,

    mem_cmd_if.controller       cmd,

    output logic                ram_en,
    output logic                ram_we,
    output logic [9:0]          ram_index,
    output logic [31:0]         ram_wdata,
    output logic [3:0]          ram_wmask,
    input  logic [31:0]         ram_rdata,

    output logic                tmr_en,
    output logic                tmr_we,
    output map_pkg::timer_sel_t tmr_sel,
    output logic [31:0]         tmr_wdata,
    input  logic [31:0]         tmr_rdata
);

    map_pkg::region_t    region;
    map_pkg::region_t    region_q;
    map_pkg::timer_sel_t sel;
    map_pkg::timer_sel_t sel_q;

    logic [31:0] ram_off;
    logic [31:0] tmr_off;
    logic        cmd_fire;
    logic        cmd_vld;
    logic        we_q;
    logic [9:0]  index_q;
    logic [31:0] wdata_q;
    logic [3:0]  wmask_q;

    // ------------------------------------------------------------------
    // address decode
    // ------------------------------------------------------------------

    assign ram_off  = cmd.addr - `RAM_BASE;
    assign tmr_off  = cmd.addr - `TIMER_BASE;
    assign cmd_fire = cmd.start && cmd.ready;

    always_comb begin
        region = map_pkg::reg_none;
        if (cmd.addr >= `RAM_BASE && ram_off < `RAM_WORDS * 4) begin
            region = map_pkg::reg_ram;
        end else if (cmd.addr >= `TIMER_BASE && tmr_off < `TIMER_SPAN) begin
            region = map_pkg::reg_timer;
        end
    end

    always_comb begin
        case ({tmr_off[3:2], 2'b00})
            `TMR_MTIME_HI: sel = map_pkg::mtime_hi;
            `TMR_CMP_LO:   sel = map_pkg::cmp_lo;
            `TMR_CMP_HI:   sel = map_pkg::cmp_hi;
            default:       sel = map_pkg::mtime_lo;
        endcase
    end

    // command register, the target blocks act one edge after transfer
    always_ff @(posedge clk) begin
        if (cmd_fire) begin
            we_q     <= cmd.write;
            region_q <= region;     // also selects the returning word
            sel_q    <= sel;
            index_q  <= ram_off[11:2];
            wdata_q  <= cmd.wdata;
            wmask_q  <= cmd.wmask;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cmd_vld         <= 1'b0;
            cmd.rdata_valid <= 1'b0;
        end else begin
            cmd_vld         <= cmd_fire;
            cmd.rdata_valid <= cmd_vld && !we_q;
        end
    end

    assign cmd.ready = !cmd_vld && !cmd.rdata_valid;

    // ------------------------------------------------------------------
    // target side
    // ------------------------------------------------------------------

    assign ram_en    = cmd_vld && (region_q == map_pkg::reg_ram);
    assign ram_we    = we_q;
    assign ram_index = index_q;
    assign ram_wdata = wdata_q;
    assign ram_wmask = wmask_q;

    assign tmr_en    = cmd_vld && (region_q == map_pkg::reg_timer);
    assign tmr_we    = we_q;
    assign tmr_sel   = sel_q;
    assign tmr_wdata = wdata_q;

    always_comb begin
        case (region_q)
            map_pkg::reg_ram:   cmd.rdata = ram_rdata;
            map_pkg::reg_timer: cmd.rdata = tmr_rdata;
            default:            cmd.rdata = 32'h0;
        endcase
    end

    // a read keeps the bus closed until its data has returned
    a_read_blocks: assert property (@(posedge clk) disable iff (!arst_n)
        cmd_fire && !cmd.write |=> !cmd_fire ##1 !cmd_fire);

endmodule

`default_nettype wire

// ==== rtl/ram_block.sv ====
`default_nettype none

`include "mem_config.svh"

module ram_block (
    input  logic        clk,
    input  logic        en,
    input  logic        we,
    input  logic [9:0]  index,
    input  logic [31:0] wdata,
    input  logic [3:0]  wmask,
    output logic [31:0] rdata
);

    logic [31:0] mem [`RAM_WORDS];

    // ------------------------------------------------------------------
    // byte masked write, registered read
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (en) begin
            if (we) begin
                for (int b = 0; b < 4; b++) begin
                    if (wmask[b]) begin
                        mem[index][8*b +: 8] <= wdata[8*b +: 8];
                    end
                end
            end else begin
                rdata <= mem[index]; // held until the next read
            end
        end
    end

    a_index_range: assert property (@(posedge clk)
        en |-> index < `RAM_WORDS);

endmodule

`default_nettype wire

// ==== rtl/timer_regs.sv ====
`default_nettype none

module timer_regs (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                en,
    input  logic                we,
    input  map_pkg::timer_sel_t sel,
    input  logic [31:0]         wdata,
    input  logic [63:0]         mtime,
    output logic [31:0]         rdata,
    output logic [63:0]         mtimecmp,
    output logic                timer_irq
);

    // mtime comes from outside, only the compare value lives here
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtimecmp <= '1;                 // keeps the interrupt quiet
        end else if (en && we) begin
            case (sel)
                map_pkg::cmp_lo: mtimecmp[31:0]  <= wdata;
                map_pkg::cmp_hi: mtimecmp[63:32] <= wdata;
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (en && !we) begin
            case (sel)
                map_pkg::mtime_lo: rdata <= mtime[31:0];
                map_pkg::mtime_hi: rdata <= mtime[63:32];
                map_pkg::cmp_lo:   rdata <= mtimecmp[31:0];
                default:           rdata <= mtimecmp[63:32];
            endcase
        end
    end

    assign timer_irq = mtime >= mtimecmp;

endmodule

`default_nettype wire

// ==== rtl/mem_subsys.sv ====
`default_nettype none

module mem_subsys (
    input  logic        clk,
    input  logic        arst_n,

    input  logic        ireq_valid,
    input  logic [31:0] ireq_addr,
    output logic        ireq_ready,
    output logic        iresp_valid,
    output logic [31:0] iresp_addr,
    output logic [31:0] iresp_inst,

    input  logic        dreq_valid,
    input  logic        dreq_wen,
    input  logic [31:0] dreq_addr,
    input  logic [31:0] dreq_wdata,
    input  logic [3:0]  dreq_wmask,
    output logic        dreq_ready,
    output logic        dresp_valid,
    output logic [31:0] dresp_addr,
    output logic [31:0] dresp_data,

    input  logic [63:0] mtime,
    output logic [63:0] mtimecmp,
    output logic        timer_irq
);

    logic                ram_en;
    logic                ram_we;
    logic [9:0]          ram_index;
    logic [31:0]         ram_wdata;
    logic [3:0]          ram_wmask;
    logic [31:0]         ram_rdata;
    logic                tmr_en;
    logic                tmr_we;
    map_pkg::timer_sel_t tmr_sel;
    logic [31:0]         tmr_wdata;
    logic [31:0]         tmr_rdata;

    mem_cmd_if cmd_bus ();

    // ------------------------------------------------------------------
    // processor ports to command bus
    // ------------------------------------------------------------------

    mem_arbiter u_arbiter (
        .clk         (clk),
        .arst_n      (arst_n),
        .ireq_valid  (ireq_valid),
        .ireq_addr   (ireq_addr),
        .ireq_ready  (ireq_ready),
        .iresp_valid (iresp_valid),
        .iresp_addr  (iresp_addr),
        .iresp_inst  (iresp_inst),
        .dreq_valid  (dreq_valid),
        .dreq_wen    (dreq_wen),
        .dreq_addr   (dreq_addr),
        .dreq_wdata  (dreq_wdata),
        .dreq_wmask  (dreq_wmask),
        .dreq_ready  (dreq_ready),
        .dresp_valid (dresp_valid),
        .dresp_addr  (dresp_addr),
        .dresp_data  (dresp_data),
        .cmd         (cmd_bus.arbiter)
    );

    mem_map_ctrl u_map_ctrl (
        .clk       (clk),
        .arst_n    (arst_n),
        .cmd       (cmd_bus.controller),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_index (ram_index),
        .ram_wdata (ram_wdata),
        .ram_wmask (ram_wmask),
        .ram_rdata (ram_rdata),
        .tmr_en    (tmr_en),
        .tmr_we    (tmr_we),
        .tmr_sel   (tmr_sel),
        .tmr_wdata (tmr_wdata),
        .tmr_rdata (tmr_rdata)
    );

    // ------------------------------------------------------------------
    // targets
    // ------------------------------------------------------------------

    ram_block u_ram (
        .clk   (clk),
        .en    (ram_en),
        .we    (ram_we),
        .index (ram_index),
        .wdata (ram_wdata),
        .wmask (ram_wmask),
        .rdata (ram_rdata)
    );

    timer_regs u_timer (
        .clk       (clk),
        .arst_n    (arst_n),
        .en        (tmr_en),
        .we        (tmr_we),
        .sel       (tmr_sel),
        .wdata     (tmr_wdata),
        .mtime     (mtime),
        .rdata     (tmr_rdata),
        .mtimecmp  (mtimecmp),
        .timer_irq (timer_irq)
    );

endmodule

`default_nettype wire

// ==== tb/tb_mem_subsys.sv ====
`default_nettype none

`include "mem_config.svh"

module tb_mem_subsys;

    localparam int TXN_LIMIT  = 200;
    localparam int MAX_CYCLES = TXN_LIMIT * 10 + 8; // ten cycles per transaction plus reset

    logic        clk;
    logic        arst_n;
    logic        ireq_valid;
    logic [31:0] ireq_addr;
    logic        ireq_ready;
    logic        iresp_valid;
    logic [31:0] iresp_addr;
    logic [31:0] iresp_inst;
    logic        dreq_valid;
    logic        dreq_wen;
    logic [31:0] dreq_addr;
    logic [31:0] dreq_wdata;
    logic [3:0]  dreq_wmask;
    logic        dreq_ready;
    logic        dresp_valid;
    logic [31:0] dresp_addr;
    logic [31:0] dresp_data;
    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic        timer_irq;

    logic [31:0] shadow_ram [`RAM_WORDS];
    logic [63:0] shadow_cmp;
    logic [31:0] addr_list [16];
    logic [31:0] iexp_addr [$];
    logic [31:0] iexp_data [$];
    logic [31:0] dexp_addr [$];
    logic [31:0] dexp_data [$];
    logic [31:0] chk_addr;
    logic [31:0] chk_data;
    logic [15:0] lfsr;
    time         last_i_time;
    time         last_d_time;
    int          cycle_count;
    int          checks;
    int          errors;

    mem_subsys DUT (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    // ------------------------------------------------------------------
    // random numbers and reference model
    // ------------------------------------------------------------------

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // taps 16 14 13 11
    endfunction

    function logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] ref_read(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - `TIMER_BASE;
        if (addr >= `RAM_BASE && addr < `RAM_BASE + `RAM_WORDS * 4) begin
            return shadow_ram[(addr - `RAM_BASE) >> 2];
        end
        if (addr >= `TIMER_BASE && off < `TIMER_SPAN) begin
            case (off[3:2])
                2'd0:    return mtime[31:0];
                2'd1:    return mtime[63:32];
                2'd2:    return shadow_cmp[31:0];
                default: return shadow_cmp[63:32];
            endcase
        end
        return 32'h0; // unmapped
    endfunction

    task automatic shadow_write(input logic [31:0] addr, input logic [31:0] wdata,
                                input logic [3:0] wmask);
        logic [31:0] off;
        off = addr - `TIMER_BASE;
        if (addr >= `RAM_BASE && addr < `RAM_BASE + `RAM_WORDS * 4) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) begin
                    shadow_ram[(addr - `RAM_BASE) >> 2][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end else if (addr >= `TIMER_BASE && off < `TIMER_SPAN) begin
            if (off[3:2] == 2'd2) begin
                shadow_cmp[31:0] = wdata;
            end else if (off[3:2] == 2'd3) begin
                shadow_cmp[63:32] = wdata;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // checking and end of run
    // ------------------------------------------------------------------

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAIL %s expected %0h got %0h", name, exp, act);
        end
    endtask

    task automatic end_run();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    always @(posedge clk) begin
        if (arst_n && iresp_valid) begin
            assert (iexp_addr.size() != 0) else begin
                errors++;
                $display("ERROR fetch response arrived with no fetch outstanding");
            end
            if (iexp_addr.size() != 0) begin
                chk_addr = iexp_addr.pop_front();
                chk_data = iexp_data.pop_front();
                check_value("iresp_addr", chk_addr, iresp_addr);
                check_value("iresp_inst", chk_data, iresp_inst);
            end
            last_i_time = $time;
        end
        if (arst_n && dresp_valid) begin
            assert (dexp_addr.size() != 0) else begin
                errors++;
                $display("ERROR load response arrived with no load outstanding");
            end
            if (dexp_addr.size() != 0) begin
                chk_addr = dexp_addr.pop_front();
                chk_data = dexp_data.pop_front();
                check_value("dresp_addr", chk_addr, dresp_addr);
                check_value("dresp_data", chk_data, dresp_data);
            end
            last_d_time = $time;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            errors++;
            $display("ERROR timeout, the run did not finish within %0d cycles", MAX_CYCLES);
            end_run();
        end
    end

    // ------------------------------------------------------------------
    // request drivers, all called a short delay after a rising edge
    // ------------------------------------------------------------------

    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic data_req(input logic wen, input logic [31:0] addr,
                            input logic [31:0] wdata, input logic [3:0] wmask);
        dreq_valid = 1'b1;
        dreq_wen   = wen;
        dreq_addr  = addr;
        dreq_wdata = wdata;
        dreq_wmask = wmask;
        @(posedge clk);
        while (!dreq_ready) @(posedge clk);
        #10;
        dreq_valid = 1'b0;
        if (wen) begin
            shadow_write(addr, wdata, wmask);
        end else begin
            dexp_addr.push_back(addr);
            dexp_data.push_back(ref_read(addr));
        end
    endtask

    task automatic inst_req(input logic [31:0] addr);
        ireq_valid = 1'b1;
        ireq_addr  = addr;
        @(posedge clk);
        while (!ireq_ready) @(posedge clk);
        #10;
        ireq_valid = 1'b0;
        iexp_addr.push_back(addr);
        iexp_data.push_back(ref_read(addr));
    endtask

    task automatic dual_req(input logic [31:0] iaddr, input logic [31:0] daddr);
        ireq_valid = 1'b1;
        ireq_addr  = iaddr;
        dreq_valid = 1'b1;
        dreq_wen   = 1'b0;
        dreq_addr  = daddr;
        @(posedge clk);
        while (!ireq_ready) @(posedge clk);  // both ports see the same ready
        #10;
        ireq_valid = 1'b0;
        dreq_valid = 1'b0;
        iexp_addr.push_back(iaddr);
        iexp_data.push_back(ref_read(iaddr));
        dexp_addr.push_back(daddr);
        dexp_data.push_back(ref_read(daddr));
    endtask

    task automatic wait_drain();
        while (iexp_addr.size() != 0 || dexp_addr.size() != 0) begin
            next_cycle();
        end
    endtask

    initial begin
        logic [31:0] a;
        arst_n     = 1'b0;
        ireq_valid = 1'b0;
        ireq_addr  = '0;
        dreq_valid = 1'b0;
        dreq_wen   = 1'b0;
        dreq_addr  = '0;
        dreq_wdata = '0;
        dreq_wmask = '0;
        mtime      = '0;
        shadow_cmp = '1;
        lfsr       = 16'd82;
        repeat (8) @(posedge clk);
        #10;
        arst_n = 1'b1;

        @(posedge clk);
        check_value("ireq_ready", 1'b1, ireq_ready);
        check_value("dreq_ready", 1'b1, dreq_ready);
        check_value("iresp_valid", 1'b0, iresp_valid);
        check_value("dresp_valid", 1'b0, dresp_valid);
        check_value("timer_irq", 1'b0, timer_irq);
        #10;

        // full words first so no byte is left unknown
        for (int i = 0; i < 16; i++) begin
            addr_list[i] = `RAM_BASE + (rand_bits(10) << 2);
            data_req(1'b1, addr_list[i], rand_bits(32), 4'hF);
        end
        for (int i = 0; i < 16; i++) begin
            logic [31:0] m;
            m = rand_bits(4);
            data_req(1'b1, addr_list[rand_bits(4)], rand_bits(32), m[3:0]);
        end
        for (int i = 0; i < 16; i++) begin
            data_req(1'b0, addr_list[i], '0, '0);
        end
        wait_drain();

        for (int i = 0; i < 16; i++) begin
            inst_req(addr_list[rand_bits(4)]);
        end
        wait_drain();

        for (int i = 0; i < 8; i++) begin
            dual_req(addr_list[rand_bits(4)], addr_list[rand_bits(4)]);
            wait_drain();
            check_value("dresp_delay", 64'd3, (last_d_time - last_i_time) / 100);
        end

        // ------------------------------------------------------------------
        // timer registers and interrupt
        // ------------------------------------------------------------------

        mtime = {rand_bits(32), rand_bits(32)};
        data_req(1'b1, `TIMER_BASE + `TMR_CMP_LO, rand_bits(32), 4'hF);
        data_req(1'b1, `TIMER_BASE + `TMR_CMP_HI, rand_bits(32), 4'hF);
        repeat (2) next_cycle();
        check_value("mtimecmp", shadow_cmp, mtimecmp);
        check_value("timer_irq", mtime >= shadow_cmp, timer_irq);
        data_req(1'b0, `TIMER_BASE + `TMR_MTIME_LO, '0, '0);
        data_req(1'b0, `TIMER_BASE + `TMR_MTIME_HI, '0, '0);
        data_req(1'b0, `TIMER_BASE + `TMR_CMP_LO, '0, '0);
        data_req(1'b0, `TIMER_BASE + `TMR_CMP_HI, '0, '0);
        wait_drain();

        data_req(1'b1, `TIMER_BASE + `TMR_CMP_LO, 32'h1, 4'hF);
        data_req(1'b1, `TIMER_BASE + `TMR_CMP_HI, 32'h1, 4'hF);
        repeat (2) next_cycle();
        check_value("mtimecmp", shadow_cmp, mtimecmp);
        for (int k = 0; k < 6; k++) begin
            mtime = 64'h0000_0000_FFFF_FFFE + k; // crosses the 32-bit boundary
            @(posedge clk);
            check_value("timer_irq", mtime >= shadow_cmp, timer_irq);
            #10;
        end
        mtime = '0;
        @(posedge clk);
        check_value("timer_irq", 1'b0, timer_irq);
        #10;

        // ------------------------------------------------------------------
        // unmapped addresses
        // ------------------------------------------------------------------

        // each address shares its low bits with a live ram word or timer register
        for (int i = 0; i < 6; i++) begin
            if (i < 3) begin
                a = addr_list[i] + `RAM_WORDS * 4;
            end else if (i == 3) begin
                a = `TIMER_BASE + `TIMER_SPAN + `TMR_CMP_LO;
            end else begin
                a = 32'h1000_0000 + addr_list[i];
            end
            data_req(1'b0, a, '0, '0);
            data_req(1'b1, a, rand_bits(32), 4'hF);
        end
        for (int i = 0; i < 6; i++) begin
            data_req(1'b0, addr_list[i], '0, '0);
        end
        data_req(1'b0, `TIMER_BASE + `TMR_CMP_LO, '0, '0);
        data_req(1'b0, `TIMER_BASE + `TMR_CMP_HI, '0, '0);
        wait_drain();
        check_value("mtimecmp", shadow_cmp, mtimecmp);

        repeat (4) next_cycle();
        assert (iexp_addr.size() == 0 && dexp_addr.size() == 0) else begin
            errors++;
            $display("ERROR responses still outstanding at the end of the run");
        end
        end_run();
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+rtl
rtl/bus_pkg.sv
rtl/map_pkg.sv
rtl/mem_cmd_if.sv
rtl/mem_arbiter.sv
rtl/mem_map_ctrl.sv
rtl/ram_block.sv
rtl/timer_regs.sv
rtl/mem_subsys.sv
tb/tb_mem_subsys.sv
